// File: logic/arch_state.sv
`timescale 1ns/1ps

module arch_state (
    input  logic               clk,
    input  logic               rst_n,

    input  commit_pkg::regid_t wa5,
    input  commit_pkg::word_t  wd5,
    input  logic               write_en1,
    input  commit_pkg::regid_t wa6,
    input  commit_pkg::word_t  wd6,
    input  logic               write_en2,

    input  commit_pkg::word_t  hi_data,
    input  commit_pkg::word_t  lo_data,
    input  logic               write_hi,
    input  logic               write_lo,

    input  commit_pkg::regid_t gpr_raddr,
    output commit_pkg::word_t  gpr_rdata,
    output commit_pkg::word_t  hi,
    output commit_pkg::word_t  lo
);
    import commit_pkg::*;

    // r0 has no storage.
    word_t regs [1:31];

    // ##################################################
    // general registers
    // ##################################################

    // lane 2 is younger, so its write goes last and wins.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (write_en1 && wa5 != R0) begin
                regs[wa5] <= wd5;
            end
            if (write_en2 && wa6 != R0) begin
                regs[wa6] <= wd6;
            end
        end
    end

    assign gpr_rdata = (gpr_raddr == R0) ? '0 : regs[gpr_raddr];

    // ##################################################
    // hi / lo
    // ##################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hi <= '0;
            lo <= '0;
        end else begin
            if (write_hi) begin
                hi <= hi_data;
            end
            if (write_lo) begin
                lo <= lo_data;
            end
        end
    end

    r0_never_written: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(write_en1 && wa5 == R0) && !(write_en2 && wa6 == R0)
    ) else $error("write to r0 requested, wa5=%h wa6=%h", wa5, wa6);

endmodule

// File: logic/commit_exc.sv
`timescale 1ns/1ps

module commit_exc (
    input  logic               exec_en1,
    input  commit_pkg::fu_t    exec_fu1,
    input  commit_pkg::regid_t exec_target1,
    input  commit_pkg::addr_t  exec_pc1,
    input  logic               exec_en2,
    input  commit_pkg::fu_t    exec_fu2,
    input  commit_pkg::regid_t exec_target2,
    input  commit_pkg::addr_t  exec_pc2,

    input  commit_pkg::word_t  alu1_result,
    input  commit_pkg::word_t  alu2_result,
    input  commit_pkg::word_t  agu_result,
    input  commit_pkg::word_t  hilo_result,
    input  commit_pkg::word_t  cop0_result,
    input  commit_pkg::addr_t  bru_link_pc,
    input  commit_pkg::dword_t mlt_result,
    input  commit_pkg::dword_t div_result,
    input  logic               hilo_write_hi,
    input  logic               hilo_write_lo,

    input  logic               exception1_en,
    input  logic               exception2_en,
    input  logic               bru_adel,

    output commit_pkg::regid_t wa5,
    output commit_pkg::regid_t wa6,
    output commit_pkg::word_t  wd5,
    output commit_pkg::word_t  wd6,
    output logic               write_en1,
    output logic               write_en2,
    output commit_pkg::word_t  hi_data,
    output commit_pkg::word_t  lo_data,
    output logic               write_hi,
    output logic               write_lo,

    output logic               push1,
    output logic               push2,
    output commit_pkg::addr_t  trace_pc1,
    output logic               trace_wen1,
    output commit_pkg::regid_t trace_wnum1,
    output commit_pkg::word_t  trace_data1,
    output commit_pkg::addr_t  trace_pc2,
    output logic               trace_wen2,
    output commit_pkg::regid_t trace_wnum2,
    output commit_pkg::word_t  trace_data2
);
    import commit_pkg::*;

    // lane 1 still retires on a branch address error so the link reg lands.
    assign push1 = exec_en1 && (!exception1_en || bru_adel);
    assign push2 = exec_en2 && !exception1_en && !exception2_en;

    // ##################################################
    // register write-back
    // ##################################################

    always_comb begin
        wa5 = R0;
        wd5 = '0;
        write_en1 = 1'b0;
        if (push1 && exec_target1 != R0) begin
            write_en1 = 1'b1;
            wa5 = exec_target1;
            unique case (exec_fu1)
                ALU1: wd5 = alu1_result;
                BRU: begin
                    wa5 = RA;
                    wd5 = bru_link_pc;
                end
                AGU:  wd5 = agu_result;
                HILO: wd5 = hilo_result;
                CP0:  wd5 = cop0_result;
                MLT:  wd5 = mlt_result[31:0];
                default: begin
                    wa5 = R0;
                    write_en1 = 1'b0;
                end
            endcase
        end
    end

    // no branch unit on lane 2.
    always_comb begin
        wa6 = R0;
        wd6 = '0;
        write_en2 = 1'b0;
        if (push2 && exec_target2 != R0) begin
            write_en2 = 1'b1;
            wa6 = exec_target2;
            unique case (exec_fu2)
                ALU2: wd6 = alu2_result;
                AGU:  wd6 = agu_result;
                HILO: wd6 = hilo_result;
                CP0:  wd6 = cop0_result;
                MLT:  wd6 = mlt_result[31:0];
                default: begin
                    wa6 = R0;
                    write_en2 = 1'b0;
                end
            endcase
        end
    end

    // ##################################################
    // hi/lo update
    // ##################################################

    always_comb begin
        write_hi = 1'b0;
        write_lo = 1'b0;
        hi_data = '0;
        lo_data = '0;
        if (push2 && (exec_fu2 == MLT || exec_fu2 == DIV)) begin
            write_hi = 1'b1;
            write_lo = 1'b1;
            {hi_data, lo_data} = (exec_fu2 == MLT) ? mlt_result : div_result;
        end else if (push1 && (exec_fu1 == MLT || exec_fu1 == DIV)) begin
            write_hi = 1'b1;
            write_lo = 1'b1;
            {hi_data, lo_data} = (exec_fu1 == MLT) ? mlt_result : div_result;
        end else if ((push2 && exec_fu2 == HILO) || (push1 && exec_fu1 == HILO)) begin
            // mthi/mtlo, one word to whichever half is strobed.
            write_hi = hilo_write_hi;
            write_lo = hilo_write_lo;
            hi_data = hilo_result;
            lo_data = hilo_result;
        end
    end

    // ##################################################
    // trace entries
    // ##################################################

    assign trace_pc1   = push1 ? exec_pc1 : '0;
    assign trace_wen1  = push1 && exec_target1 != R0;
    assign trace_wnum1 = push1 ? exec_target1 : R0;
    assign trace_data1 = trace_wen1 ? wd5 : '0;

    assign trace_pc2   = push2 ? exec_pc2 : '0;
    assign trace_wen2  = push2 && exec_target2 != R0;
    assign trace_wnum2 = push2 ? exec_target2 : R0;
    assign trace_data2 = trace_wen2 ? wd6 : '0;

    always_comb begin
        assert final (!write_en1 || (push1 && wa5 != R0))
            else $error("lane 1 write without retire or to r0, wa5=%h", wa5);
        assert final (!write_en2 || (push2 && wa6 != R0))
            else $error("lane 2 write without retire or to r0, wa6=%h", wa6);
        assert final (!(write_hi || write_lo) || push1 || push2)
            else $error("hi/lo written with no lane retiring");
    end

endmodule

// File: logic/commit_pkg.sv
package commit_pkg;

    // ##################################################
    // basic data types
    // ##################################################

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  regid_t;

    // mult/div result, hi half on top.
    typedef logic [63:0] dword_t;

    // functional unit that produced a lane's result.
    typedef enum logic [3:0] {
        ALU1,
        ALU2,
        BRU,
        AGU,
        HILO,
        CP0,
        MLT,
        DIV,
        NONE
    } fu_t;

    // ##################################################
    // register numbers
    // ##################################################

    localparam regid_t R0 = 5'd0;
    // link register for branch-and-link.
    localparam regid_t RA = 5'd31;

    // ##################################################
    // trace queue sizing
    // ##################################################

    localparam int DEBUG_DEPTH = 8;
    localparam int DEBUG_PTR_W = $clog2(DEBUG_DEPTH);

endpackage

// File: logic/commit_top.sv
`timescale 1ns/1ps

module commit_top (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               exec_en1,
    input  commit_pkg::fu_t    exec_fu1,
    input  commit_pkg::regid_t exec_target1,
    input  commit_pkg::addr_t  exec_pc1,
    input  logic               exec_en2,
    input  commit_pkg::fu_t    exec_fu2,
    input  commit_pkg::regid_t exec_target2,
    input  commit_pkg::addr_t  exec_pc2,
    input  commit_pkg::word_t  alu1_result,
    input  commit_pkg::word_t  alu2_result,
    input  commit_pkg::word_t  agu_result,
    input  commit_pkg::word_t  hilo_result,
    input  commit_pkg::word_t  cop0_result,
    input  commit_pkg::addr_t  bru_link_pc,
    input  commit_pkg::dword_t mlt_result,
    input  commit_pkg::dword_t div_result,
    input  logic               hilo_write_hi,
    input  logic               hilo_write_lo,
    input  logic               exception1_en,
    input  logic               exception2_en,
    input  logic               bru_adel,

    input  commit_pkg::regid_t gpr_raddr,
    output commit_pkg::word_t  gpr_rdata,
    output commit_pkg::word_t  hi,
    output commit_pkg::word_t  lo,

    output logic               debug_stall,
    output logic               debug_wb_valid,
    output commit_pkg::addr_t  debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output commit_pkg::regid_t debug_wb_rf_wnum,
    output commit_pkg::word_t  debug_wb_rf_wdata
);
    import commit_pkg::*;

    // register file and hi/lo write side.
    regid_t wa5, wa6;
    word_t  wd5, wd6;
    logic   write_en1, write_en2;
    word_t  hi_data, lo_data;
    logic   write_hi, write_lo;

    // retired entries into the trace queue.
    logic   push1, push2;
    addr_t  trace_pc1, trace_pc2;
    logic   trace_wen1, trace_wen2;
    regid_t trace_wnum1, trace_wnum2;
    word_t  trace_data1, trace_data2;

    commit_exc  u_commit_exc  (.*);
    arch_state  u_arch_state  (.*);
    debug_queue u_debug_queue (.*);

endmodule

// File: logic/debug_queue.sv
`timescale 1ns/1ps

module debug_queue (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               push1,
    input  logic               push2,
    input  commit_pkg::addr_t  trace_pc1,
    input  logic               trace_wen1,
    input  commit_pkg::regid_t trace_wnum1,
    input  commit_pkg::word_t  trace_data1,
    input  commit_pkg::addr_t  trace_pc2,
    input  logic               trace_wen2,
    input  commit_pkg::regid_t trace_wnum2,
    input  commit_pkg::word_t  trace_data2,

    output logic               debug_stall,
    output logic               debug_wb_valid,
    output commit_pkg::addr_t  debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output commit_pkg::regid_t debug_wb_rf_wnum,
    output commit_pkg::word_t  debug_wb_rf_wdata
);
    import commit_pkg::*;

    addr_t  pc_mem   [DEBUG_DEPTH];
    logic   wen_mem  [DEBUG_DEPTH];
    regid_t wnum_mem [DEBUG_DEPTH];
    word_t  data_mem [DEBUG_DEPTH];

    logic [DEBUG_PTR_W-1:0] wr_ptr;
    logic [DEBUG_PTR_W-1:0] rd_ptr;
    logic [DEBUG_PTR_W:0]   count;
    logic [DEBUG_PTR_W:0]   count_next;
    logic [1:0]             n_push;
    logic                   pop;

    // first incoming entry; lane 2 alone takes the lane 1 slot.
    addr_t  in_pc;
    logic   in_wen;
    regid_t in_wnum;
    word_t  in_data;

    addr_t  head_pc;
    logic   head_wen;
    regid_t head_wnum;
    word_t  head_data;

    assign n_push  = {1'b0, push1} + {1'b0, push2};
    assign in_pc   = push1 ? trace_pc1 : trace_pc2;
    assign in_wen  = push1 ? trace_wen1 : trace_wen2;
    assign in_wnum = push1 ? trace_wnum1 : trace_wnum2;
    assign in_data = push1 ? trace_data1 : trace_data2;

    // ##################################################
    // storage
    // ##################################################

    always_ff @(posedge clk) begin
        if (n_push != 2'd0) begin
            pc_mem[wr_ptr]   <= in_pc;
            wen_mem[wr_ptr]  <= in_wen;
            wnum_mem[wr_ptr] <= in_wnum;
            data_mem[wr_ptr] <= in_data;
        end
        if (n_push == 2'd2) begin
            pc_mem[wr_ptr + 1'b1]   <= trace_pc2;
            wen_mem[wr_ptr + 1'b1]  <= trace_wen2;
            wnum_mem[wr_ptr + 1'b1] <= trace_wnum2;
            data_mem[wr_ptr + 1'b1] <= trace_data2;
        end
    end

    // empty queue lets the incoming entry straight through.
    always_comb begin
        if (count != '0) begin
            head_pc   = pc_mem[rd_ptr];
            head_wen  = wen_mem[rd_ptr];
            head_wnum = wnum_mem[rd_ptr];
            head_data = data_mem[rd_ptr];
        end else begin
            head_pc   = in_pc;
            head_wen  = in_wen;
            head_wnum = in_wnum;
            head_data = in_data;
        end
    end

    assign pop = (count != '0) || (n_push != 2'd0);
    assign count_next = count + (DEBUG_PTR_W+1)'(n_push) - (DEBUG_PTR_W+1)'(pop);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            wr_ptr <= wr_ptr + DEBUG_PTR_W'(n_push);
            rd_ptr <= rd_ptr + DEBUG_PTR_W'(pop);
            count <= count_next;
        end
    end

    // fewer than two slots free.
    assign debug_stall = count > (DEBUG_PTR_W+1)'(DEBUG_DEPTH - 2);

    // ##################################################
    // trace port
    // ##################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            debug_wb_valid <= 1'b0;
            debug_wb_rf_wen <= '0;
        end else begin
            debug_wb_valid <= pop;
            debug_wb_rf_wen <= {4{pop && head_wen}};
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            debug_wb_pc <= head_pc;
            debug_wb_rf_wnum <= head_wnum;
            debug_wb_rf_wdata <= head_data;
        end
    end

    no_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        count_next <= (DEBUG_PTR_W+1)'(DEBUG_DEPTH)
    ) else $error("trace queue overflow, count=%h push=%h", count, n_push);

endmodule

// File: run.sh
#!/bin/sh
# build and run the commit testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_commit -o sim_commit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_commit > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tb.f
logic/commit_pkg.sv
logic/commit_exc.sv
logic/arch_state.sv
logic/debug_queue.sv
logic/commit_top.sv
tests/tb_commit.sv

// File: tests/commit_stim.txt
# I en1 fu1 tgt1 pc1 en2 fu2 tgt2 pc2 alu1 alu2 agu hilo cop0 link mlt div whi wlo exc1 exc2 adel
# T pc wen wnum data / S r num value / S h hi lo; fu: 0 alu1 1 alu2 2 bru 3 agu 4 hilo 5 cp0 6 mlt 7 div 8 none
I 1 0 01 00001000 1 1 02 00001004 11110000 22220000 33330000 0 0 0 0 0 0 0 0 0 0
T 00001000 1 01 11110000
T 00001004 1 02 22220000
I 1 3 03 00001008 1 5 04 0000100c 0 0 aaaa0003 0 cccc0004 0 0 0 0 0 0 0 0
T 00001008 1 03 aaaa0003
T 0000100c 1 04 cccc0004
I 1 2 1f 00001010 0 8 00 00000000 0 0 0 0 0 00001014 0 0 0 0 0 0 0
T 00001010 1 1f 00001014
I 1 2 1f 00001020 1 1 05 00001024 0 55550000 0 0 0 00002024 0 0 0 0 1 0 1
T 00001020 1 1f 00002024
I 1 0 06 00001030 1 1 07 00001034 66660000 77770000 0 0 0 0 0 0 0 0 0 1 0
T 00001030 1 06 66660000
I 1 0 00 00001040 1 1 08 00001044 deadbeef 88880000 0 0 0 0 0 0 0 0 0 0 0
T 00001040 0 00 00000000
T 00001044 1 08 88880000
I 1 0 09 00001050 1 1 09 00001054 9999aaaa 9999bbbb 0 0 0 0 0 0 0 0 0 0 0
T 00001050 1 09 9999aaaa
T 00001054 1 09 9999bbbb
I 1 6 0a 00001060 1 7 00 00001064 0 0 0 0 0 0 0123456789abcdef fedcba9876543210 0 0 0 0 0
T 00001060 1 0a 89abcdef
T 00001064 0 00 00000000
I 1 4 00 00001070 0 8 00 00000000 0 0 0 5a5a5a5a 0 0 0 0 1 0 0 0 0
T 00001070 0 00 00000000
I 1 4 0b 00001074 0 8 00 00000000 0 0 0 0b0b0b0b 0 0 0 0 0 0 0 0 0
T 00001074 1 0b 0b0b0b0b
I 1 0 0c 00002000 1 1 0d 00002004 c0000000 d0000000 0 0 0 0 0 0 0 0 0 0 0
T 00002000 1 0c c0000000
T 00002004 1 0d d0000000
I 1 0 0c 00002008 1 1 0d 0000200c c0000001 d0000001 0 0 0 0 0 0 0 0 0 0 0
T 00002008 1 0c c0000001
T 0000200c 1 0d d0000001
I 1 0 0c 00002010 1 1 0d 00002014 c0000002 d0000002 0 0 0 0 0 0 0 0 0 0 0
T 00002010 1 0c c0000002
T 00002014 1 0d d0000002
I 1 0 0c 00002018 1 1 0d 0000201c c0000003 d0000003 0 0 0 0 0 0 0 0 0 0 0
T 00002018 1 0c c0000003
T 0000201c 1 0d d0000003
I 1 0 0c 00002020 1 1 0d 00002024 c0000004 d0000004 0 0 0 0 0 0 0 0 0 0 0
T 00002020 1 0c c0000004
T 00002024 1 0d d0000004
I 1 0 0c 00002028 1 1 0d 0000202c c0000005 d0000005 0 0 0 0 0 0 0 0 0 0 0
T 00002028 1 0c c0000005
T 0000202c 1 0d d0000005
I 1 0 0c 00002030 1 1 0d 00002034 c0000006 d0000006 0 0 0 0 0 0 0 0 0 0 0
T 00002030 1 0c c0000006
T 00002034 1 0d d0000006
I 1 0 0c 00002038 1 1 0d 0000203c c0000007 d0000007 0 0 0 0 0 0 0 0 0 0 0
T 00002038 1 0c c0000007
T 0000203c 1 0d d0000007
I 1 0 0c 00002040 1 1 0d 00002044 c0000008 d0000008 0 0 0 0 0 0 0 0 0 0 0
T 00002040 1 0c c0000008
T 00002044 1 0d d0000008
I 1 0 0c 00002048 1 1 0d 0000204c c0000009 d0000009 0 0 0 0 0 0 0 0 0 0 0
T 00002048 1 0c c0000009
T 0000204c 1 0d d0000009
S r 01 11110000
S r 02 22220000
S r 03 aaaa0003
S r 04 cccc0004
S r 1f 00002024
S r 05 00000000
S r 06 66660000
S r 07 00000000
S r 00 00000000
S r 08 88880000
S r 09 9999bbbb
S r 0a 89abcdef
S r 0b 0b0b0b0b
S r 0c c0000009
S r 0d d0000009
S h 5a5a5a5a 76543210

// File: tests/tb_commit.sv
`timescale 1ns/1ps

module tb_commit;
    import commit_pkg::*;

    typedef struct {
        logic         en1;
        logic [3:0]   fu1;
        logic [4:0]   tgt1;
        logic [31:0]  pc1;
        logic         en2;
        logic [3:0]   fu2;
        logic [4:0]   tgt2;
        logic [31:0]  pc2;
        logic [31:0]  alu1, alu2, agu, hilo, cop0, link;
        logic [63:0]  mlt, div;
        logic         whi, wlo, exc1, exc2, adel;
    } in_rec_t;

    typedef struct {
        logic [31:0] pc;
        logic        wen;
        logic [4:0]  wnum;
        logic [31:0] data;
    } trace_rec_t;

    typedef struct {
        logic        is_hilo;
        logic [4:0]  idx;
        logic [31:0] a;
        logic [31:0] b;
    } state_rec_t;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic exec_en1 = 1'b0;
    fu_t exec_fu1 = NONE;
    regid_t exec_target1 = '0;
    addr_t exec_pc1 = '0;
    logic exec_en2 = 1'b0;
    fu_t exec_fu2 = NONE;
    regid_t exec_target2 = '0;
    addr_t exec_pc2 = '0;
    word_t alu1_result = '0;
    word_t alu2_result = '0;
    word_t agu_result = '0;
    word_t hilo_result = '0;
    word_t cop0_result = '0;
    addr_t bru_link_pc = '0;
    dword_t mlt_result = '0;
    dword_t div_result = '0;
    logic hilo_write_hi = 1'b0;
    logic hilo_write_lo = 1'b0;
    logic exception1_en = 1'b0;
    logic exception2_en = 1'b0;
    logic bru_adel = 1'b0;
    regid_t gpr_raddr = '0;
    word_t gpr_rdata, hi, lo;
    logic debug_stall, debug_wb_valid;
    addr_t debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    regid_t debug_wb_rf_wnum;
    word_t debug_wb_rf_wdata;

    in_rec_t    in_q[$];
    trace_rec_t trace_q[$];
    state_rec_t state_q[$];
    int trace_idx = 0;
    int value_errors = 0;
    int other_errors = 0;
    int cycles = 0;
    int cycle_limit = 1000000;
    logic stall_seen = 1'b0;
    logic [31:0] lfsr = 32'heee0_b8bd;

    commit_top dut (.*);

    always #50 clk = ~clk;

    // galois form, taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    task automatic drive_inputs(input in_rec_t r, input logic active);
        exec_en1 <= active && r.en1;
        exec_fu1 <= fu_t'(r.fu1);
        exec_target1 <= r.tgt1;
        exec_pc1 <= r.pc1;
        exec_en2 <= active && r.en2;
        exec_fu2 <= fu_t'(r.fu2);
        exec_target2 <= r.tgt2;
        exec_pc2 <= r.pc2;
        alu1_result <= r.alu1;
        alu2_result <= r.alu2;
        agu_result <= r.agu;
        hilo_result <= r.hilo;
        cop0_result <= r.cop0;
        bru_link_pc <= r.link;
        mlt_result <= r.mlt;
        div_result <= r.div;
        hilo_write_hi <= r.whi;
        hilo_write_lo <= r.wlo;
        exception1_en <= r.exc1;
        exception2_en <= r.exc2;
        bru_adel <= r.adel;
    endtask

    task automatic load_records();
        int fd;
        int code;
        string tag;
        string line;
        in_rec_t ir;
        trace_rec_t tr;
        state_rec_t sr;
        fd = $fopen("tests/commit_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            other_errors++;
            return;
        end
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                code = $fgets(line, fd);
            end else if (tag == "I") begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    ir.en1, ir.fu1, ir.tgt1, ir.pc1, ir.en2, ir.fu2, ir.tgt2, ir.pc2,
                    ir.alu1, ir.alu2, ir.agu, ir.hilo, ir.cop0, ir.link, ir.mlt, ir.div,
                    ir.whi, ir.wlo, ir.exc1, ir.exc2, ir.adel);
                in_q.push_back(ir);
            end else if (tag == "T") begin
                code = $fscanf(fd, "%h %h %h %h", tr.pc, tr.wen, tr.wnum, tr.data);
                trace_q.push_back(tr);
            end else if (tag == "S") begin
                code = $fscanf(fd, "%s", line);
                sr.is_hilo = (line == "h");
                if (sr.is_hilo) begin
                    sr.idx = '0;
                    code = $fscanf(fd, "%h %h", sr.a, sr.b);
                end else begin
                    code = $fscanf(fd, "%h %h", sr.idx, sr.a);
                end
                state_q.push_back(sr);
            end else begin
                $display("unknown record tag %s in the stimulus file", tag);
                other_errors++;
            end
        end
        $fclose(fd);
    endtask

    // trace monitor, sampled mid-cycle.
    always @(negedge clk) begin
        if (rst_n && debug_wb_valid) begin
            if (trace_idx >= trace_q.size()) begin
                $display("trace entry at pc %h arrived with no record left", debug_wb_pc);
                other_errors++;
            end else begin
                if (debug_wb_pc !== trace_q[trace_idx].pc) begin
                    $display("error debug_wb_pc got %h expected %h",
                        debug_wb_pc, trace_q[trace_idx].pc);
                    value_errors++;
                end
                if (debug_wb_rf_wen !== {4{trace_q[trace_idx].wen}}) begin
                    $display("error debug_wb_rf_wen got %h expected %h",
                        debug_wb_rf_wen, {4{trace_q[trace_idx].wen}});
                    value_errors++;
                end
                if (debug_wb_rf_wnum !== trace_q[trace_idx].wnum) begin
                    $display("error debug_wb_rf_wnum got %h expected %h",
                        debug_wb_rf_wnum, trace_q[trace_idx].wnum);
                    value_errors++;
                end
                if (debug_wb_rf_wdata !== trace_q[trace_idx].data) begin
                    $display("error debug_wb_rf_wdata got %h expected %h",
                        debug_wb_rf_wdata, trace_q[trace_idx].data);
                    value_errors++;
                end
                trace_idx++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d trace entries seen",
                cycles, trace_idx, trace_q.size());
            $display("errors: %0d value, %0d other", value_errors, other_errors + 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int i;
        load_records();
        cycle_limit = 2 * (in_q.size() + trace_q.size() + state_q.size()) + DEBUG_DEPTH + 100;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        i = 0;
        while (i < in_q.size()) begin
            // decide mid-cycle while the stall level is settled.
            @(negedge clk);
            if (debug_stall) begin
                stall_seen = 1'b1;
            end
            if (debug_stall || (next_bit() && next_bit() && next_bit())) begin
                @(posedge clk);
                drive_inputs(in_q[i], 1'b0);
            end else begin
                @(posedge clk);
                drive_inputs(in_q[i], 1'b1);
                i++;
            end
        end
        @(posedge clk);
        exec_en1 <= 1'b0;
        exec_en2 <= 1'b0;
        while (trace_idx < trace_q.size() || debug_wb_valid) begin
            @(negedge clk);
        end
        // drained queue has all slots free.
        if (debug_stall !== 1'b0) begin
            $display("error debug_stall got %h expected %h", debug_stall, 1'b0);
            value_errors++;
        end
        if (!stall_seen) begin
            $display("debug_stall never rose during the burst");
            other_errors++;
        end
        // final architectural state.
        foreach (state_q[k]) begin
            @(posedge clk);
            gpr_raddr <= state_q[k].idx;
            @(negedge clk);
            if (state_q[k].is_hilo) begin
                if (hi !== state_q[k].a) begin
                    $display("error hi got %h expected %h", hi, state_q[k].a);
                    value_errors++;
                end
                if (lo !== state_q[k].b) begin
                    $display("error lo got %h expected %h", lo, state_q[k].b);
                    value_errors++;
                end
            end else if (gpr_rdata !== state_q[k].a) begin
                $display("error gpr_rdata[%h] got %h expected %h",
                    state_q[k].idx, gpr_rdata, state_q[k].a);
                value_errors++;
            end
        end
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
